/* avr_periph_pkg.sv */
package avr_periph_pkg;

   // ====================
   // Widths and basic types
   // ====================

   localparam int DATA_W = 8;
   localparam int ADR_W  = 6;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADR_W-1:0]  io_adr_t;

   // Master request on the I/O bus
   typedef struct packed {
      io_adr_t adr;
      logic    iore;
      logic    iowe;
      data_t   dbus_in;
   } io_bus_t;

   // Read response of one slave
   typedef struct packed {
      logic  out_en;
      data_t dbus;
   } io_slv_t;

   localparam int N_SLAVES = 4;

   // ====================
   // Interrupt vector
   // ====================

   localparam int IRQS_WIDTH  = 23;
   localparam int IRQ_EXT1    = 1;
   localparam int IRQ_TC0_CMP = 14;
   localparam int IRQ_TC0_OVF = 15;

   // ====================
   // I/O addresses
   // ====================

   // Port A
   localparam io_adr_t PINA_ADR  = 6'h19;
   localparam io_adr_t DDRA_ADR  = 6'h1A;
   localparam io_adr_t PORTA_ADR = 6'h1B;

   // Port B
   localparam io_adr_t PINB_ADR  = 6'h16;
   localparam io_adr_t DDRB_ADR  = 6'h17;
   localparam io_adr_t PORTB_ADR = 6'h18;

   // Timer 0
   localparam io_adr_t TCCR0_ADR  = 6'h33;
   localparam io_adr_t TCNT0_ADR  = 6'h32;
   localparam io_adr_t OCR0_ADR   = 6'h31;
   localparam io_adr_t TIMSK0_ADR = 6'h37;
   localparam io_adr_t TIFR0_ADR  = 6'h36;

   // Watchdog
   localparam io_adr_t WDTCR_ADR = 6'h21;

endpackage

/* io_port.sv */
module io_port import avr_periph_pkg::*; #(
   parameter io_adr_t portx_adr  = PORTA_ADR,
   parameter io_adr_t ddrx_adr   = DDRA_ADR,
   parameter io_adr_t pinx_adr   = PINA_ADR,
   parameter int      port_width = DATA_W
) (
   input  logic                  cp2,
   input  logic                  rst,
   input  io_bus_t               bus,
   input  logic [port_width-1:0] pinx,
   output io_slv_t               slv,
   output logic [port_width-1:0] portx,
   output logic [port_width-1:0] ddrx
);

   logic                  portx_wr;
   logic                  ddrx_wr;
   logic [port_width-1:0] pin_meta;
   logic [port_width-1:0] pin_sync;

   assign portx_wr = bus.iowe && (bus.adr == portx_adr);
   assign ddrx_wr  = bus.iowe && (bus.adr == ddrx_adr);

   // PORT and DDR registers
   always_ff @(posedge cp2) begin
      if (rst) begin
         portx <= '0;
         ddrx  <= '0;
      end else begin
         if (portx_wr) begin
            portx <= bus.dbus_in[port_width-1:0];
         end
         if (ddrx_wr) begin
            ddrx <= bus.dbus_in[port_width-1:0];
         end
      end
   end

   // Two-flop PIN synchronizer
   always_ff @(posedge cp2) begin
      if (rst) begin
         pin_meta <= '0;
         pin_sync <= '0;
      end else begin
         pin_meta <= pinx;
         pin_sync <= pin_meta;
      end
   end

   // Read response with narrow ports zero extended
   always_comb begin
      slv = '0;
      if (bus.iore) begin
         case (bus.adr)
            portx_adr: begin
               slv.out_en = 1'b1;
               slv.dbus   = data_t'(portx);
            end
            ddrx_adr: begin
               slv.out_en = 1'b1;
               slv.dbus   = data_t'(ddrx);
            end
            pinx_adr: begin
               slv.out_en = 1'b1;
               slv.dbus   = data_t'(pin_sync);
            end
            default: slv = '0;
         endcase
      end
   end

endmodule

/* timer0.sv */
module timer0 import avr_periph_pkg::*; (
   input  logic    cp2,
   input  logic    rst,
   input  io_bus_t bus,
   input  logic    tmr_ext,
   input  logic    irq_ack_cmp,
   input  logic    irq_ack_ovf,
   output io_slv_t slv,
   output logic    irq_cmp,
   output logic    irq_ovf
);

   // Flag positions in TIFR0 and TIMSK0
   localparam int TOV_BIT = 0;
   localparam int OCF_BIT = 1;

   data_t      tccr0;
   data_t      tcnt0;
   data_t      ocr0;
   data_t      timsk0;
   data_t      tifr_rd;
   data_t      tcnt_inc;
   logic       tov;
   logic       ocf;
   logic [2:0] presc;
   logic       ext_meta;
   logic       ext_sync;
   logic       ext_last;
   logic       ext_rise;
   logic       cnt_en;
   logic       ovf_evt;
   logic       cmp_evt;
   logic       tov_clr;
   logic       ocf_clr;
   logic       tifr_wr;

   // ====================
   // Count source
   // ====================

   assign ext_rise = ext_sync && !ext_last;

   always_comb begin
      case (tccr0[1:0])
         2'd0:    cnt_en = 1'b0;
         2'd1:    cnt_en = 1'b1;
         2'd2:    cnt_en = (presc == 3'd7);
         default: cnt_en = ext_rise;
      endcase
   end

   // A CPU write to TCNT0 wins over counting
   assign tcnt_inc = tcnt0 + 8'd1;
   assign ovf_evt  = cnt_en && !(bus.iowe && bus.adr == TCNT0_ADR) && (tcnt0 == 8'hFF);
   assign cmp_evt  = cnt_en && !(bus.iowe && bus.adr == TCNT0_ADR) && (tcnt_inc == ocr0);

   assign tifr_wr = bus.iowe && (bus.adr == TIFR0_ADR);
   assign tov_clr = irq_ack_ovf || (tifr_wr && bus.dbus_in[TOV_BIT]);
   assign ocf_clr = irq_ack_cmp || (tifr_wr && bus.dbus_in[OCF_BIT]);

   always_ff @(posedge cp2) begin
      if (rst) begin
         tccr0    <= '0;
         tcnt0    <= '0;
         ocr0     <= '0;
         timsk0   <= '0;
         tov      <= 1'b0;
         ocf      <= 1'b0;
         presc    <= '0;
         ext_meta <= 1'b0;
         ext_sync <= 1'b0;
         ext_last <= 1'b0;
      end else begin
         presc    <= presc + 3'd1;
         ext_meta <= tmr_ext;
         ext_sync <= ext_meta;
         ext_last <= ext_sync;
         if (bus.iowe && bus.adr == TCCR0_ADR) begin
            tccr0 <= bus.dbus_in;
         end
         if (bus.iowe && bus.adr == OCR0_ADR) begin
            ocr0 <= bus.dbus_in;
         end
         if (bus.iowe && bus.adr == TIMSK0_ADR) begin
            timsk0 <= bus.dbus_in;
         end
         if (bus.iowe && bus.adr == TCNT0_ADR) begin
            tcnt0 <= bus.dbus_in;
         end else if (cnt_en) begin
            tcnt0 <= tcnt_inc;
         end
         // Set has priority over clear
         tov <= ovf_evt || (tov && !tov_clr);
         ocf <= cmp_evt || (ocf && !ocf_clr);
      end
   end

   assign irq_ovf = tov && timsk0[TOV_BIT];
   assign irq_cmp = ocf && timsk0[OCF_BIT];

   // ====================
   // Read response
   // ====================

   always_comb begin
      tifr_rd          = '0;
      tifr_rd[TOV_BIT] = tov;
      tifr_rd[OCF_BIT] = ocf;
      slv              = '0;
      if (bus.iore) begin
         slv.out_en = 1'b1;
         case (bus.adr)
            TCCR0_ADR:  slv.dbus = tccr0;
            TCNT0_ADR:  slv.dbus = tcnt0;
            OCR0_ADR:   slv.dbus = ocr0;
            TIMSK0_ADR: slv.dbus = timsk0;
            TIFR0_ADR:  slv.dbus = tifr_rd;
            default:    slv      = '0;
         endcase
      end
   end

endmodule

/* watchdog.sv */
module watchdog import avr_periph_pkg::*; (
   input  logic    cp2,
   input  logic    rst,
   input  io_bus_t bus,
   input  logic    wdri,
   output io_slv_t slv,
   output logic    wdovf
);

   localparam int CNT_W   = 12;
   localparam int WDE_BIT = 3;

   data_t            wdtcr;
   logic [CNT_W-1:0] cnt;
   logic [CNT_W-1:0] period_m1;
   logic             wdtcr_wr;
   logic             wd_en;
   logic             wd_clr;
   logic             timeout;

   assign wdtcr_wr = bus.iowe && (bus.adr == WDTCR_ADR);
   assign wd_en    = wdtcr[WDE_BIT];
   assign wd_clr   = wdtcr_wr || wdri;

   // Last count before wrap in a period of 16 << WDP
   assign period_m1 = (CNT_W'(16) << wdtcr[2:0]) - CNT_W'(1);
   assign timeout   = wd_en && !wd_clr && (cnt == period_m1);

   always_ff @(posedge cp2) begin
      if (rst) begin
         wdtcr <= '0;
         cnt   <= '0;
         wdovf <= 1'b0;
      end else begin
         if (wdtcr_wr) begin
            wdtcr <= bus.dbus_in;
         end
         // Pulse lands P cycles after the last clear
         wdovf <= timeout;
         if (wd_clr || timeout) begin
            cnt <= '0;
         end else if (wd_en) begin
            cnt <= cnt + CNT_W'(1);
         end
      end
   end

   // WDTCR reads back as written
   always_comb begin
      slv = '0;
      if (bus.iore && bus.adr == WDTCR_ADR) begin
         slv.out_en = 1'b1;
         slv.dbus   = wdtcr;
      end
   end

endmodule

/* io_read_mux.sv */
module io_read_mux import avr_periph_pkg::*; #(
   parameter int n_slaves = N_SLAVES
) (
   input  io_slv_t [n_slaves-1:0] slv_in,
   output logic                   out_en,
   output data_t                  dbus_out
);

   // Chain runs from the top index down, so slot 0 has the last word
   io_slv_t [n_slaves:0] chain;

   assign chain[n_slaves] = '0;

   for (genvar i = 0; i < n_slaves; i++) begin : g_chain
      assign chain[i].out_en = slv_in[i].out_en | chain[i+1].out_en;
      assign chain[i].dbus   = slv_in[i].out_en ? slv_in[i].dbus : chain[i+1].dbus;
   end

   // Zero when no slave responds
   assign out_en   = chain[0].out_en;
   assign dbus_out = chain[0].dbus;

endmodule

/* peripherals.sv */
module peripherals import avr_periph_pkg::*; #(
   parameter bit impl_wdt = 1'b1
) (
   input  logic                  cp2,
   input  logic                  rst,
   input  io_bus_t               bus,
   input  logic [IRQS_WIDTH-1:0] irq_ack,
   input  logic                  ext_irq1,
   input  data_t                 porta_pinx,
   input  data_t                 portb_pinx,
   input  logic                  tmr_ext_1,
   input  logic                  wdri,
   output logic                  out_en,
   output data_t                 dbus_out,
   output logic [IRQS_WIDTH-1:0] irqlines,
   output data_t                 porta_portx,
   output data_t                 porta_ddrx,
   output data_t                 portb_portx,
   output data_t                 portb_ddrx,
   output logic                  wdt_wdovf
);

   // Read slots, lower index wins
   localparam int SLV_WDT   = 0;
   localparam int SLV_TMR   = 1;
   localparam int SLV_PORTA = 2;
   localparam int SLV_PORTB = 3;

   io_slv_t [N_SLAVES-1:0] slv;
   logic                   tc0_cmp_irq;
   logic                   tc0_ovf_irq;

   // ====================
   // Watchdog
   // ====================

   if (impl_wdt) begin : g_wdt
      watchdog u_wdt (
         .cp2   (cp2),
         .rst   (rst),
         .bus   (bus),
         .wdri  (wdri),
         .slv   (slv[SLV_WDT]),
         .wdovf (wdt_wdovf)
      );
   end else begin : g_no_wdt
      assign slv[SLV_WDT] = '0;
      assign wdt_wdovf    = 1'b0;
   end

   timer0 u_timer0 (
      .cp2         (cp2),
      .rst         (rst),
      .bus         (bus),
      .tmr_ext     (tmr_ext_1),
      .irq_ack_cmp (irq_ack[IRQ_TC0_CMP]),
      .irq_ack_ovf (irq_ack[IRQ_TC0_OVF]),
      .slv         (slv[SLV_TMR]),
      .irq_cmp     (tc0_cmp_irq),
      .irq_ovf     (tc0_ovf_irq)
   );

   // ====================
   // Parallel ports
   // ====================

   io_port #(
      .portx_adr  (PORTA_ADR),
      .ddrx_adr   (DDRA_ADR),
      .pinx_adr   (PINA_ADR),
      .port_width (DATA_W)
   ) u_porta (
      .cp2   (cp2),
      .rst   (rst),
      .bus   (bus),
      .pinx  (porta_pinx),
      .slv   (slv[SLV_PORTA]),
      .portx (porta_portx),
      .ddrx  (porta_ddrx)
   );

   io_port #(
      .portx_adr  (PORTB_ADR),
      .ddrx_adr   (DDRB_ADR),
      .pinx_adr   (PINB_ADR),
      .port_width (DATA_W)
   ) u_portb (
      .cp2   (cp2),
      .rst   (rst),
      .bus   (bus),
      .pinx  (portb_pinx),
      .slv   (slv[SLV_PORTB]),
      .portx (portb_portx),
      .ddrx  (portb_ddrx)
   );

   io_read_mux #(
      .n_slaves (N_SLAVES)
   ) u_read_mux (
      .slv_in   (slv),
      .out_en   (out_en),
      .dbus_out (dbus_out)
   );

   // Only ext_irq1 and the two timer 0 lines are live
   assign irqlines = (IRQS_WIDTH'(ext_irq1) << IRQ_EXT1)
                   | (IRQS_WIDTH'(tc0_cmp_irq) << IRQ_TC0_CMP)
                   | (IRQS_WIDTH'(tc0_ovf_irq) << IRQ_TC0_OVF);

endmodule

/* peripherals_props.sv */
module peripherals_props import avr_periph_pkg::*; (
   input logic                  cp2,
   input logic                  rst,
   input io_bus_t               bus,
   input logic                  out_en,
   input logic                  wdt_wdovf,
   input logic [IRQS_WIDTH-1:0] irqlines
);

   // Lines driven by this block
   localparam logic [IRQS_WIDTH-1:0] LIVE_IRQS = (IRQS_WIDTH'(1) << IRQ_EXT1)
                                             | (IRQS_WIDTH'(1) << IRQ_TC0_CMP)
                                             | (IRQS_WIDTH'(1) << IRQ_TC0_OVF);

   // Read data only answers a read strobe
   a_out_en_needs_iore: assert property (@(posedge cp2) disable iff (rst)
      out_en |-> bus.iore)
      else $error("out_en high without iore");

   // Timeout is a single cycle pulse
   a_wdovf_one_cycle: assert property (@(posedge cp2) disable iff (rst)
      wdt_wdovf |=> !wdt_wdovf)
      else $error("wdt_wdovf high for two cycles in a row");

   a_unused_irqs_low: assert property (@(posedge cp2) disable iff (rst)
      (irqlines & ~LIVE_IRQS) == '0)
      else $error("unused irqlines bit is set");

endmodule

bind peripherals peripherals_props u_props (
   .cp2       (cp2),
   .rst       (rst),
   .bus       (bus),
   .out_en    (out_en),
   .wdt_wdovf (wdt_wdovf),
   .irqlines  (irqlines)
);

/* peripherals_tb.sv */
module peripherals_tb import avr_periph_pkg::*; ();

   localparam int    TIMEOUT_CYCLES = 4000;
   localparam int    N_ROUNDS       = 8;
   localparam data_t START_VAL      = 8'd250;
   localparam data_t CMP_VAL        = 8'd253;
   localparam int    CMP_DELAY      = int'(CMP_VAL) - int'(START_VAL);
   localparam int    OVF_DELAY      = 256 - int'(START_VAL);

   logic                  cp2;
   logic                  rst;
   io_bus_t               bus;
   logic [IRQS_WIDTH-1:0] irq_ack;
   logic                  ext_irq1;
   data_t                 porta_pinx;
   data_t                 portb_pinx;
   logic                  tmr_ext_1;
   logic                  wdri;
   logic                  out_en;
   data_t                 dbus_out;
   logic [IRQS_WIDTH-1:0] irqlines;
   data_t                 porta_portx;
   data_t                 porta_ddrx;
   data_t                 portb_portx;
   data_t                 portb_ddrx;
   logic                  wdt_wdovf;

   int    cyc        = 0;
   int    read_errs  = 0;
   int    other_errs = 0;

   // Model state
   data_t shadow [0:63];
   data_t pina_exp;
   data_t pinb_exp;
   data_t tifr_exp;
   data_t tcnt_base;
   int    tcnt_cyc;
   int    ext_pulses;

   // Reads waiting for the compare process
   io_adr_t rd_adr_q [$];
   io_slv_t rd_got_q [$];
   io_slv_t rd_exp_q [$];
   event    rd_done;

   peripherals #(
      .impl_wdt (1'b1)
   ) dut (
      .cp2         (cp2),
      .rst         (rst),
      .bus         (bus),
      .irq_ack     (irq_ack),
      .ext_irq1    (ext_irq1),
      .porta_pinx  (porta_pinx),
      .portb_pinx  (portb_pinx),
      .tmr_ext_1   (tmr_ext_1),
      .wdri        (wdri),
      .out_en      (out_en),
      .dbus_out    (dbus_out),
      .irqlines    (irqlines),
      .porta_portx (porta_portx),
      .porta_ddrx  (porta_ddrx),
      .portb_portx (portb_portx),
      .portb_ddrx  (portb_ddrx),
      .wdt_wdovf   (wdt_wdovf)
   );

   initial cp2 = 1'b0;
   always #50 cp2 = ~cp2;

   always @(posedge cp2) cyc <= cyc + 1;

   // ====================
   // Reference model
   // ====================

   function automatic io_slv_t model_read(input io_adr_t adr);
      io_slv_t exp;
      int      d;
      exp        = '0;
      d          = cyc - tcnt_cyc;
      exp.out_en = 1'b1;
      case (adr)
         PINA_ADR:  exp.dbus = pina_exp;
         PINB_ADR:  exp.dbus = pinb_exp;
         TIFR0_ADR: exp.dbus = tifr_exp;
         PORTA_ADR, DDRA_ADR, PORTB_ADR, DDRB_ADR,
         TCCR0_ADR, OCR0_ADR, TIMSK0_ADR, WDTCR_ADR: exp.dbus = shadow[adr];
         TCNT0_ADR: begin
            // Counted edges since the last TCNT0 write
            case (shadow[TCCR0_ADR][1:0])
               2'd0:    exp.dbus = tcnt_base;
               2'd1:    exp.dbus = data_t'(int'(tcnt_base) + d);
               2'd2:    exp.dbus = data_t'(int'(tcnt_base) + d / 8);
               default: exp.dbus = data_t'(int'(tcnt_base) + ext_pulses);
            endcase
         end
         default: exp = '0;
      endcase
      return exp;
   endfunction

   function automatic int wdt_period(input logic [2:0] wdp);
      return 16 << wdp;
   endfunction

   // ====================
   // Bus tasks
   // ====================

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge cp2);
         #10;
      end
   endtask

   task automatic io_write(input io_adr_t adr, input data_t data);
      bus.adr     = adr;
      bus.dbus_in = data;
      bus.iowe    = 1'b1;
      @(posedge cp2);
      #10;
      bus.iowe    = 1'b0;
      bus.dbus_in = '0;
      shadow[adr] = data;
      if (adr == TCNT0_ADR) begin
         tcnt_base  = data;
         tcnt_cyc   = cyc;
         ext_pulses = 0;
      end
   endtask

   task automatic io_read(input io_adr_t adr);
      io_slv_t got;
      bus.adr  = adr;
      bus.iore = 1'b1;
      #80;
      got.out_en = out_en;
      got.dbus   = dbus_out;
      rd_adr_q.push_back(adr);
      rd_got_q.push_back(got);
      rd_exp_q.push_back(model_read(adr));
      -> rd_done;
      @(posedge cp2);
      #10;
      bus.iore = 1'b0;
   endtask

   task automatic report_error(input string msg);
      other_errs++;
      $display("error at %0t: %s", $time, msg);
   endtask

   initial begin : compare_reads
      io_adr_t adr;
      io_slv_t got;
      io_slv_t exp;
      forever begin
         @(rd_done);
         while (rd_got_q.size() > 0) begin
            adr = rd_adr_q.pop_front();
            got = rd_got_q.pop_front();
            exp = rd_exp_q.pop_front();
            if (got !== exp) begin
               read_errs++;
               $display("error at %0t: address 0x%02h read en %0b data 0x%02h, expected %0b 0x%02h",
                        $time, adr, got.out_en, got.dbus, exp.out_en, exp.dbus);
            end
         end
      end
   end

   // ====================
   // Tests
   // ====================

   task automatic compare_port_outputs();
      if (porta_portx !== shadow[PORTA_ADR]) begin
         report_error($sformatf("porta_portx is 0x%02h", porta_portx));
      end
      if (porta_ddrx !== shadow[DDRA_ADR]) begin
         report_error($sformatf("porta_ddrx is 0x%02h", porta_ddrx));
      end
      if (portb_portx !== shadow[PORTB_ADR]) begin
         report_error($sformatf("portb_portx is 0x%02h", portb_portx));
      end
      if (portb_ddrx !== shadow[DDRB_ADR]) begin
         report_error($sformatf("portb_ddrx is 0x%02h", portb_ddrx));
      end
   endtask

   task automatic port_readback();
      io_adr_t regs [4];
      io_adr_t unmapped [4];
      regs     = '{PORTA_ADR, DDRA_ADR, PORTB_ADR, DDRB_ADR};
      unmapped = '{6'h00, 6'h10, 6'h20, 6'h3F};
      for (int r = 0; r < N_ROUNDS; r++) begin
         foreach (regs[i]) begin
            io_write(regs[i], data_t'($urandom));
            compare_port_outputs();
         end
         foreach (regs[i]) begin
            io_read(regs[i]);
         end
         io_read(unmapped[r % 4]);
      end
   endtask

   task automatic pin_sync_reads();
      for (int r = 0; r < N_ROUNDS; r++) begin
         porta_pinx = data_t'($urandom);
         portb_pinx = data_t'($urandom);
         pina_exp   = porta_pinx;
         pinb_exp   = portb_pinx;
         wait_cycles(3);
         io_read(PINA_ADR);
         io_read(PINB_ADR);
      end
   endtask

   task automatic timer_counting();
      // Every cycle
      io_write(TCCR0_ADR, 8'h01);
      for (int r = 0; r < 4; r++) begin
         io_write(TCNT0_ADR, data_t'($urandom));
         wait_cycles(1 + int'($urandom % 40));
         io_read(TCNT0_ADR);
      end
      // Prescaler with reads at whole multiples of 8
      io_write(TCCR0_ADR, 8'h02);
      for (int r = 0; r < 3; r++) begin
         io_write(TCNT0_ADR, data_t'($urandom));
         wait_cycles(8 * (1 + int'($urandom % 4)));
         io_read(TCNT0_ADR);
      end
      // External clock pulses
      io_write(TCCR0_ADR, 8'h03);
      io_write(TCNT0_ADR, data_t'($urandom));
      for (int p = 0; p < 5; p++) begin
         tmr_ext_1 = 1'b1;
         wait_cycles(2);
         tmr_ext_1 = 1'b0;
         wait_cycles(2);
         ext_pulses++;
      end
      // Synchronizer and edge register drain
      wait_cycles(4);
      io_read(TCNT0_ADR);
      io_read(TCCR0_ADR);
   endtask

   task automatic sample_irq(input logic exp_cmp, input logic exp_ovf);
      #80;
      if (irqlines[IRQ_TC0_CMP] !== exp_cmp) begin
         report_error($sformatf("compare irq is %0b, expected %0b",
                                irqlines[IRQ_TC0_CMP], exp_cmp));
      end
      if (irqlines[IRQ_TC0_OVF] !== exp_ovf) begin
         report_error($sformatf("overflow irq is %0b, expected %0b",
                                irqlines[IRQ_TC0_OVF], exp_ovf));
      end
      @(posedge cp2);
      #10;
   endtask

   task automatic pulse_ack(input int pos);
      irq_ack      = '0;
      irq_ack[pos] = 1'b1;
      @(posedge cp2);
      #10;
      irq_ack = '0;
   endtask

   task automatic timer_interrupts();
      io_write(TCCR0_ADR, 8'h00);
      io_write(OCR0_ADR, CMP_VAL);
      io_write(TIMSK0_ADR, 8'h03);
      io_write(TIFR0_ADR, 8'h03);
      io_read(OCR0_ADR);
      io_read(TIMSK0_ADR);
      io_write(TCCR0_ADR, 8'h01);
      for (int run = 0; run < 2; run++) begin
         io_write(TCNT0_ADR, START_VAL);
         for (int d = 0; d < 8; d++) begin
            sample_irq(d >= CMP_DELAY, d >= OVF_DELAY);
         end
         tifr_exp = 8'h03;
         io_read(TIFR0_ADR);
         if (run == 0) begin
            pulse_ack(IRQ_TC0_CMP);
            sample_irq(1'b0, 1'b1);
            pulse_ack(IRQ_TC0_OVF);
            sample_irq(1'b0, 1'b0);
         end else begin
            io_write(TIFR0_ADR, 8'h02);
            sample_irq(1'b0, 1'b1);
            io_write(TIFR0_ADR, 8'h01);
            sample_irq(1'b0, 1'b0);
         end
      end
      io_write(TCCR0_ADR, 8'h00);
   endtask

   task automatic ext_irq_passthrough();
      for (int r = 0; r < 16; r++) begin
         ext_irq1 = 1'($urandom);
         #80;
         if (irqlines[IRQ_EXT1] !== ext_irq1) begin
            report_error("irqlines[1] does not follow ext_irq1");
         end
         @(posedge cp2);
         #10;
      end
      ext_irq1 = 1'b0;
   endtask

   task automatic wdt_pulse_check(input logic [2:0] wdp);
      int period;
      period = wdt_period(wdp);
      io_write(WDTCR_ADR, {5'b00001, wdp});
      for (int d = 0; d <= period + 2; d++) begin
         #80;
         if (wdt_wdovf !== (d == period)) begin
            report_error($sformatf("wdt_wdovf is %0b %0d cycles after enable, period %0d",
                                   wdt_wdovf, d, period));
         end
         @(posedge cp2);
         #10;
      end
      io_read(WDTCR_ADR);
      io_write(WDTCR_ADR, 8'h00);
   endtask

   task automatic watchdog_timeouts();
      wdt_pulse_check(3'd0);
      wdt_pulse_check(3'd2);
      // wdri every 10 cycles keeps the 16 cycle period from expiring
      io_write(WDTCR_ADR, 8'h08);
      for (int c = 0; c < 200; c++) begin
         wdri = (c % 10 == 9);
         #80;
         if (wdt_wdovf !== 1'b0) begin
            report_error("watchdog timed out although wdri kept restarting it");
         end
         @(posedge cp2);
         #10;
      end
      wdri = 1'b0;
      io_write(WDTCR_ADR, 8'h00);
   endtask

   // ====================
   // Main sequence
   // ====================

   initial begin : main_sequence
      void'($urandom(76096));
      rst        = 1'b1;
      bus        = '0;
      irq_ack    = '0;
      ext_irq1   = 1'b0;
      porta_pinx = '0;
      portb_pinx = '0;
      tmr_ext_1  = 1'b0;
      wdri       = 1'b0;
      foreach (shadow[i]) begin
         shadow[i] = '0;
      end
      pina_exp   = '0;
      pinb_exp   = '0;
      tifr_exp   = '0;
      tcnt_base  = '0;
      tcnt_cyc   = 0;
      ext_pulses = 0;
      repeat (5) @(posedge cp2);
      #10;
      rst = 1'b0;
      if (out_en !== 1'b0 || irqlines !== '0 || wdt_wdovf !== 1'b0) begin
         report_error("outputs are not idle after reset");
      end
      if (porta_ddrx !== 8'h00 || portb_ddrx !== 8'h00) begin
         report_error("ports are not inputs after reset");
      end
      port_readback();
      pin_sync_reads();
      timer_counting();
      timer_interrupts();
      ext_irq_passthrough();
      watchdog_timeouts();
      @(posedge cp2);
      #10;
      $display("Errors: %0d in reads, %0d in other checks, %0d in total",
               read_errs, other_errs, read_errs + other_errs);
      if (read_errs + other_errs == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin : timeout_guard
      repeat (TIMEOUT_CYCLES) @(posedge cp2);
      $display("Run stopped: tests still busy after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* sim.f */
avr_periph_pkg.sv
io_port.sv
timer0.sv
watchdog.sv
io_read_mux.sv
peripherals.sv
peripherals_props.sv
peripherals_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = peripherals_tb
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
